// File: files.f
+incdir+source
source/flash_pkg.sv
source/flash_reader.sv
source/axil_flash_port.sv
source/flash_xip_top.sv
testbench/spi_flash_model.sv
testbench/tb_flash_xip.sv

// File: testbench/tb_flash_xip.sv
// Testbench for the SPI flash execute-in-place port.
// Drives LCG-based AXI4-Lite reads and writes into the DUT and checks every
// response against words built from the flash contents rule.

`timescale 1ns/1ps
`include "flash_params.svh"

module tb_flash_xip;
    import flash_pkg::*;

    localparam int n_random   = 40;
    localparam int n_runs     = 5;
    localparam int run_len    = 8;
    localparam int n_alias    = 12;
    localparam int n_bp_runs  = 2;
    localparam int bp_len     = 6;
    localparam int n_writes   = 10;
    localparam int n_transactions =
        n_random + n_runs * run_len + n_alias + n_bp_runs * bp_len + n_writes + 1;
    localparam int watchdog_cycles = n_transactions * 200 + 1000;

    logic        clk;
    logic        reset;
    logic        awvalid;
    logic        awready;
    logic [23:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [23:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        flash_csn;
    logic        flash_clk;
    logic [3:0]  flash_io_out;
    logic [3:0]  flash_io_oe;
    logic [3:0]  flash_io_in;
    logic [3:0]  model_io;
    logic        cmd_error;
    logic [31:0] lcg_state;
    int          b_count;

    // Shared io lines. The controller wins where it drives.
    assign flash_io_in = (flash_io_oe & flash_io_out) | (~flash_io_oe & model_io);

    flash_xip_top #(
        .dual_io (`FLASH_DUAL_IO)
    ) uut (
        .clk (clk), .reset (reset),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .flash_csn (flash_csn), .flash_clk (flash_clk), .flash_io_out (flash_io_out),
        .flash_io_oe (flash_io_oe), .flash_io_in (flash_io_in)
    );

    spi_flash_model #(
        .dual_io (`FLASH_DUAL_IO)
    ) flash_dev (
        .csn       (flash_csn),
        .sclk      (flash_clk),
        .io_in     (flash_io_in),
        .io_out    (model_io),
        .cmd_error (cmd_error)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_on_error($sformatf("MISMATCH %s expected %h actual %h", test, exp, act));
    endtask

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function int rand_below(input int n);
        return int'((lcg_next() >> 16) % n);  // The low LCG bits repeat quickly.
    endfunction

    function logic [23:0] rand_word_addr();
        logic [31:0] r;
        r = lcg_next();
        return {r[31:10], 2'b00};
    endfunction

    // Byte at the word address lands in bits 7:0.
    function automatic logic [31:0] expected_word(input logic [23:0] addr);
        logic [23:0] a;
        a = {addr[23:2], 2'b00};
        return {flash_dev.byte_at(a + 24'd3), flash_dev.byte_at(a + 24'd2),
                flash_dev.byte_at(a + 24'd1), flash_dev.byte_at(a)};
    endfunction

    task automatic check_reset_state();
        assert (flash_csn === 1'b1) else report_mismatch("reset_state", 1, flash_csn);
        assert (flash_clk === 1'b1) else report_mismatch("reset_state", 1, flash_clk);
        assert (flash_io_oe === 4'd0) else report_mismatch("reset_state", 0, flash_io_oe);
        assert (rvalid === 1'b0) else report_mismatch("reset_state", 0, rvalid);
        assert (bvalid === 1'b0) else report_mismatch("reset_state", 0, bvalid);
        assert (arready === 1'b1) else report_mismatch("reset_state", 1, arready);
        assert (awready === 1'b1) else report_mismatch("reset_state", 1, awready);
        assert (wready === 1'b1) else report_mismatch("reset_state", 1, wready);
    endtask

    // Entered and left on a falling edge. hold keeps rready low that many cycles.
    task automatic read_word(input string test, input logic [23:0] addr, input int hold);
        logic [31:0] exp;
        logic [31:0] seen;
        exp     = expected_word(addr);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) @(negedge clk);
        @(negedge clk);  // Address taken on the rising edge in between.
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        seen = rdata;
        repeat (hold) begin
            @(negedge clk);
            assert (rvalid) else stop_on_error("rvalid dropped while rready was low");
            assert (rdata == seen) else report_mismatch(test, seen, rdata);
        end
        assert (rdata == exp) else report_mismatch(test, exp, rdata);
        assert (rresp == RESP_OKAY) else report_mismatch(test, RESP_OKAY, rresp);
        assert (!cmd_error) else stop_on_error("Flash model received a wrong read command");
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Issues aw and w with the second one gap cycles after the first.
    task automatic write_once(input logic [23:0] addr, input logic [31:0] data,
                              input bit aw_first, input int gap);
        int cyc;
        int aw_start;
        int w_start;
        bit aw_done;
        bit w_done;
        bit aw_fire;
        bit w_fire;
        cyc      = 0;
        aw_done  = 1'b0;
        w_done   = 1'b0;
        aw_start = aw_first ? 0 : gap;
        w_start  = aw_first ? gap : 0;
        while (!aw_done || !w_done) begin
            if (cyc == aw_start) begin
                awvalid = 1'b1;
                awaddr  = addr;
            end
            if (cyc == w_start) begin
                wvalid = 1'b1;
                wdata  = data;
                wstrb  = 4'hF;
            end
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            @(negedge clk);
            if (aw_fire) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_fire) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            cyc++;
        end
    endtask

    // Counts write responses; each one must be SLVERR.
    always @(negedge clk) begin
        if (!reset && bvalid && bready) begin
            b_count = b_count + 1;
            assert (bresp == RESP_SLVERR)
                else report_mismatch("write_rejected", RESP_SLVERR, bresp);
        end
    end

    initial begin
        #(watchdog_cycles * 10);
        stop_on_error("Watchdog expired before the tests finished");
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [23:0] base;
        logic [23:0] w_addr;
        logic [31:0] w_data;
        bit          aw_first;
        int          gap;
        int          i;
        int          j;
        clk       = 1'b0;
        reset     = 1'b1;
        awvalid   = 1'b0;
        awaddr    = 24'd0;
        wvalid    = 1'b0;
        wdata     = 32'd0;
        wstrb     = 4'd0;
        bready    = 1'b1;
        arvalid   = 1'b0;
        araddr    = 24'd0;
        rready    = 1'b0;
        lcg_state = 32'h1159;
        b_count   = 0;

        repeat (3) begin
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();

        for (i = 0; i < n_random; i++) begin
            read_word("random_reads", rand_word_addr(), 0);
        end

        // First run starts three words below the top so it wraps.
        for (i = 0; i < n_runs; i++) begin
            base = (i == 0) ? 24'hFFFFF4 : rand_word_addr();
            for (j = 0; j < run_len; j++) begin
                read_word("sequential_stream", base + 24'(j * 4), 0);
            end
        end

        for (i = 0; i < n_alias / 2; i++) begin
            base = rand_word_addr();
            read_word("unaligned_alias", base | 24'(rand_below(4)), 0);
            read_word("unaligned_alias", (base + 24'd4) | 24'(rand_below(4)), 0);
        end

        for (i = 0; i < n_bp_runs; i++) begin
            base = rand_word_addr();
            for (j = 0; j < bp_len; j++) begin
                read_word("read_backpressure", base + 24'(j * 4), rand_below(31));
            end
        end

        for (i = 0; i < n_writes; i++) begin
            w_addr   = rand_word_addr();
            w_data   = lcg_next();
            aw_first = (rand_below(2) == 1);
            gap      = rand_below(6);
            write_once(w_addr, w_data, aw_first, gap);
            wait (b_count >= i + 1);
            repeat (4) @(negedge clk);
            assert (b_count == i + 1) else stop_on_error("A write got more than one response");
        end
        read_word("write_rejected", rand_word_addr(), 0);

        $display("Test OK");
        $finish;
    end

endmodule

// File: testbench/spi_flash_model.sv
// Behavioural SPI NOR flash for simulation.
// Answers the single-line read (03) or the dual-I/O read (BB) and streams bytes
// whose values follow from their address; byte_at() gives the contents rule.

`timescale 1ns/1ps
`include "flash_params.svh"

module spi_flash_model #(
    parameter bit dual_io = `FLASH_DUAL_IO
) (
    input  logic       csn,
    input  logic       sclk,
    input  logic [3:0] io_in,
    output logic [3:0] io_out,
    output logic       cmd_error
);
    import flash_pkg::*;

    localparam flash_cmd_e expected_cmd =
        flash_cmd_e'(dual_io ? CMD_DUAL_IO_READ : CMD_READ);
    localparam int addr_end    = dual_io ? 20 : 32;        // Clocks up to the last address bit.
    localparam int header_clks = dual_io ? 24 : 32;        // Mode clocks follow in dual mode.
    localparam int data_bits   = dual_io ? 2 : 1;

    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [23:0] cur_addr;
    logic [7:0]  cur_byte;
    int          edge_cnt;
    int          bit_pos;
    int          sel;

    // Contents: low byte of a * 37 + (a >> 8) + 5A.
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        logic [31:0] sum;
        sum = a * 32'd37 + (a >> 8) + 32'h5A;
        return sum[7:0];
    endfunction

    initial begin
        io_out    = 4'd0;
        cmd_error = 1'b0;
        cmd       = 8'd0;
        addr      = 24'd0;
        edge_cnt  = 0;
    end

    // A new session starts on the falling chip select.
    always @(negedge csn) begin
        edge_cnt = 0;
        cmd      = 8'd0;
        addr     = 24'd0;
    end

    // Command and address bits are taken on the rising clock.
    always @(posedge sclk) begin
        if (!csn) begin
            if (edge_cnt < 8) begin
                cmd = {cmd[6:0], io_in[0]};
            end else if (edge_cnt < addr_end) begin
                if (dual_io) addr = {addr[21:0], io_in[1:0]};
                else addr = {addr[22:0], io_in[0]};
            end
            edge_cnt = edge_cnt + 1;
            if (edge_cnt == 8 && cmd != expected_cmd) cmd_error = 1'b1;
        end
    end

    // Data goes out on the falling clock, MSB first, address wraps at 16 MB.
    always @(negedge sclk) begin
        if (!csn && edge_cnt >= header_clks) begin
            bit_pos  = (edge_cnt - header_clks) * data_bits;
            cur_addr = addr + 24'(bit_pos / 8);
            cur_byte = byte_at(cur_addr);
            sel      = 7 - (bit_pos % 8);
            if (dual_io) io_out = {2'b00, cur_byte[sel], cur_byte[sel - 1]};
            else io_out = {2'b00, cur_byte[sel], 1'b0};  // Single mode answers on io1.
        end
    end

endmodule

// File: source/flash_xip_top.sv
// Execute-in-place port onto an SPI NOR flash.
// AXI4-Lite slave on one side, flash pins on the other; io lines 3:2 stay idle.

`timescale 1ns/1ps
`include "flash_params.svh"

module flash_xip_top #(
    parameter bit dual_io = `FLASH_DUAL_IO
) (
    input  logic                     clk,
    input  logic                     reset,
    // AXI4-Lite slave
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`FLASH_ADDR_W-1:0] awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [`FLASH_DATA_W-1:0] wdata,
    input  logic [3:0]               wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`FLASH_ADDR_W-1:0] araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`FLASH_DATA_W-1:0] rdata,
    output logic [1:0]               rresp,
    // Flash pins
    output logic                     flash_csn,
    output logic                     flash_clk,
    output logic [3:0]               flash_io_out,
    output logic [3:0]               flash_io_oe,
    input  logic [3:0]               flash_io_in
);
    logic                     session;
    logic [`FLASH_ADDR_W-1:0] session_addr;
    logic                     keep_streaming;
    logic                     word_valid;
    logic [`FLASH_DATA_W-1:0] word_data;

    axil_flash_port port (
        .clk            (clk),
        .reset          (reset),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .session        (session),
        .session_addr   (session_addr),
        .keep_streaming (keep_streaming),
        .word_valid     (word_valid),
        .word_data      (word_data)
    );

    flash_reader #(
        .dual_io (dual_io)
    ) reader (
        .clk            (clk),
        .reset          (reset),
        .session        (session),
        .session_addr   (session_addr),
        .keep_streaming (keep_streaming),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .flash_csn      (flash_csn),
        .flash_clk      (flash_clk),
        .flash_io_out   (flash_io_out),
        .flash_io_oe    (flash_io_oe),
        .flash_io_in    (flash_io_in)
    );

endmodule

// File: source/axil_flash_port.sv
// AXI4-Lite read slave in front of the flash reader.
// Keeps one prefetched word and the reader session open for sequential reads.
// Every write is answered with SLVERR once both aw and w have arrived.

`timescale 1ns/1ps
`include "flash_params.svh"

module axil_flash_port (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`FLASH_ADDR_W-1:0] awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [`FLASH_DATA_W-1:0] wdata,
    input  logic [3:0]               wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`FLASH_ADDR_W-1:0] araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`FLASH_DATA_W-1:0] rdata,
    output logic [1:0]               rresp,
    output logic                     session,
    output logic [`FLASH_ADDR_W-1:0] session_addr,
    output logic                     keep_streaming,
    input  logic                     word_valid,
    input  logic [`FLASH_DATA_W-1:0] word_data
);
    import flash_pkg::*;

    localparam logic [`FLASH_ADDR_W-1:0] word_step = 'd4;

    logic [`FLASH_ADDR_W-1:0] next_addr;  // Word the reader delivers next.
    logic [`FLASH_ADDR_W-1:0] slot_addr;
    logic [`FLASH_DATA_W-1:0] slot_data;
    logic [`FLASH_ADDR_W-1:0] ar_word;
    logic slot_valid;
    logic live;
    logic pend;
    logic ks_q;
    logic ar_fire, slot_hit, flight_hit, restart;
    logic word_in, take_slot, word_to_r, fill_slot;
    logic aw_got, w_got, aw_fire, w_fire, write_done;

    // ------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------
    assign arready    = !rvalid && !pend;
    assign ar_fire    = arvalid && arready;
    assign ar_word    = {araddr[`FLASH_ADDR_W-1:2], 2'b00};
    assign slot_hit   = slot_valid && (slot_addr == ar_word);
    assign flight_hit = live && (next_addr == ar_word);
    assign restart    = ar_fire && !slot_hit && !flight_hit;
    assign word_in    = word_valid && session;  // Stale words during a restart drop out.

    assign take_slot = ar_fire && slot_hit;
    assign word_to_r = word_in && ((ar_fire && flight_hit) || (!ar_fire && pend));
    assign fill_slot = word_in && (take_slot || (!ar_fire && !pend && !slot_valid));

    // The next word may only be started while there is room for it.
    assign keep_streaming = !slot_valid || ar_fire;

    assign rresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            session      <= 1'b0;
            session_addr <= '0;
            next_addr    <= '0;
            live         <= 1'b0;
            pend         <= 1'b0;
            ks_q         <= 1'b0;
            slot_valid   <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            ks_q <= keep_streaming;  // Value the reader saw at the end of the word.

            if (restart) begin
                session      <= 1'b0;  // One cycle low aborts the old session.
                session_addr <= ar_word;
            end else if (pend) begin
                session <= 1'b1;
            end

            if (restart) begin
                next_addr <= ar_word;
                live      <= 1'b1;
            end else if (word_in) begin
                next_addr <= next_addr + word_step;
                if (!ks_q) begin
                    live <= 1'b0;
                end
            end

            if (restart || (ar_fire && flight_hit && !word_in)) begin
                pend <= 1'b1;
            end else if (word_to_r) begin
                pend <= 1'b0;
            end

            if (fill_slot) begin
                slot_valid <= 1'b1;
            end else if (ar_fire) begin
                slot_valid <= 1'b0;
            end

            if (take_slot || word_to_r) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_slot) begin
            rdata <= slot_data;
        end else if (word_to_r) begin
            rdata <= word_data;
        end
        if (fill_slot) begin
            slot_data <= word_data;
            slot_addr <= next_addr;
        end
    end

    // ------------------------------------------------------------------
    // Write rejection
    // ------------------------------------------------------------------
    assign awready    = !aw_got;
    assign wready     = !w_got;
    assign aw_fire    = awvalid && awready;
    assign w_fire     = wvalid && wready;
    assign write_done = (aw_got || aw_fire) && (w_got || w_fire) && (!bvalid || bready);
    assign bresp      = RESP_SLVERR;

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
        end else if (write_done) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b1;
        end else begin
            if (aw_fire) aw_got <= 1'b1;
            if (w_fire) w_got <= 1'b1;
            if (bready) bvalid <= 1'b0;
        end
    end

    // Checks
    rdata_held: assert property (
        @(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

    session_aligned: assert property (
        @(posedge clk) disable iff (reset)
        session |-> session_addr[1:0] == 2'b00
    );

    write_payload_held: assert property (
        @(posedge clk) disable iff (reset)
        (awvalid && !awready |=> awvalid && $stable(awaddr)) and
        (wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
    );

endmodule

// File: source/flash_reader.sv
// Bit-level SPI NOR read engine.
// Holding session high opens a read at session_addr and streams 32-bit words
// out on word_valid for as long as keep_streaming is high at the end of each word.
// The flash clock runs at half the system clock.

`timescale 1ns/1ps
`include "flash_params.svh"

module flash_reader #(
    parameter bit dual_io = `FLASH_DUAL_IO
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     session,
    input  logic [`FLASH_ADDR_W-1:0] session_addr,
    input  logic                     keep_streaming,
    output logic                     word_valid,
    output logic [`FLASH_DATA_W-1:0] word_data,
    output logic                     flash_csn,
    output logic                     flash_clk,
    output logic [3:0]               flash_io_out,
    output logic [3:0]               flash_io_oe,
    input  logic [3:0]               flash_io_in
);
    import flash_pkg::*;

    localparam logic [3:0] io_cycles = dual_io ? 4'd4 : 4'd8;  // Flash clocks per byte.
    localparam flash_cmd_e read_cmd  =
        flash_cmd_e'(dual_io ? CMD_DUAL_IO_READ : CMD_READ);

    flash_seq_e seq;
    logic [7:0] shift_buf;
    logic [3:0] bit_cnt;
    logic [3:0] oe_cnt;
    logic       cmd_phase;
    logic       closed;
    logic       wide;
    logic       oe_on;

    // The command byte always goes out on io0, even in dual mode.
    assign wide  = dual_io && !cmd_phase;
    assign oe_on = (oe_cnt != 4'd0);

    // ------------------------------------------------------------------
    // Serial engine
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        word_valid <= 1'b0;
        if (reset || !session) begin
            seq          <= SEQ_CMD;
            bit_cnt      <= 4'd0;
            oe_cnt       <= 4'd0;
            cmd_phase    <= 1'b0;
            closed       <= 1'b0;
            flash_csn    <= 1'b1;
            flash_clk    <= 1'b1;
            flash_io_out <= 4'd0;
            flash_io_oe  <= 4'd0;
        end else if (closed) begin
            // Session ended by the port, wait here for session to drop.
            flash_csn   <= 1'b1;
            flash_clk   <= 1'b1;
            flash_io_oe <= 4'd0;
        end else begin
            flash_csn <= 1'b0;
            if (bit_cnt != 4'd0) begin
                if (flash_clk) begin
                    flash_clk <= 1'b0;  // Falling edge, drive the next bits.
                    if (wide) begin
                        flash_io_out <= {2'b00, shift_buf[7:6]};
                        flash_io_oe  <= {2'b00, oe_on, oe_on};
                    end else begin
                        flash_io_out <= {3'b000, shift_buf[7]};
                        flash_io_oe  <= {3'b000, oe_on};
                    end
                    if (oe_on) begin
                        oe_cnt <= oe_cnt - 4'd1;
                    end
                end else begin
                    flash_clk <= 1'b1;  // Rising edge, sample.
                    if (wide) begin
                        shift_buf <= {shift_buf[5:0], flash_io_in[1:0]};
                    end else begin
                        shift_buf <= {shift_buf[6:0], flash_io_in[1]};
                    end
                    bit_cnt <= bit_cnt - 4'd1;
                end
            end else begin
                case (seq)
                    SEQ_CMD: begin
                        shift_buf <= read_cmd;
                        bit_cnt   <= 4'd8;
                        oe_cnt    <= 4'd8;
                        cmd_phase <= 1'b1;
                        seq       <= SEQ_ADDR_HI;
                    end
                    SEQ_ADDR_HI: begin
                        shift_buf <= session_addr[23:16];
                        bit_cnt   <= io_cycles;
                        oe_cnt    <= io_cycles;
                        cmd_phase <= 1'b0;
                        seq       <= SEQ_ADDR_MID;
                    end
                    SEQ_ADDR_MID: begin
                        shift_buf <= session_addr[15:8];
                        bit_cnt   <= io_cycles;
                        oe_cnt    <= io_cycles;
                        seq       <= SEQ_ADDR_LO;
                    end
                    SEQ_ADDR_LO: begin
                        shift_buf <= session_addr[7:0];
                        bit_cnt   <= io_cycles;
                        oe_cnt    <= io_cycles;
                        seq       <= dual_io ? SEQ_MODE : SEQ_FIRST;
                    end
                    SEQ_MODE: begin
                        // Mode bits M7-0 of zero, last nibble left for turnaround.
                        shift_buf <= 8'h00;
                        bit_cnt   <= 4'd4;
                        oe_cnt    <= 4'd3;
                        seq       <= SEQ_FIRST;
                    end
                    SEQ_FIRST: begin
                        bit_cnt     <= io_cycles;
                        oe_cnt      <= 4'd0;
                        flash_io_oe <= 4'd0;  // Flash owns the bus from here on.
                        seq         <= SEQ_BYTE1;
                    end
                    SEQ_BYTE1: begin
                        word_data[7:0] <= shift_buf;  // Byte at the word address.
                        bit_cnt        <= io_cycles;
                        seq            <= SEQ_BYTE2;
                    end
                    SEQ_BYTE2: begin
                        word_data[15:8] <= shift_buf;
                        bit_cnt         <= io_cycles;
                        seq             <= SEQ_BYTE3;
                    end
                    SEQ_BYTE3: begin
                        word_data[23:16] <= shift_buf;
                        bit_cnt          <= io_cycles;
                        seq              <= SEQ_WORD;
                    end
                    SEQ_WORD: begin
                        word_data[31:24] <= shift_buf;
                        word_valid       <= 1'b1;
                        if (keep_streaming) begin
                            bit_cnt <= io_cycles;  // Straight on with the next word.
                            seq     <= SEQ_BYTE1;
                        end else begin
                            closed <= 1'b1;
                        end
                    end
                    default: begin
                        seq <= SEQ_CMD;
                    end
                endcase
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    word_needs_select: assert property (
        @(posedge clk) disable iff (reset)
        word_valid |-> !flash_csn
    );

    data_slot_released: assert property (
        @(posedge clk) disable iff (reset)
        seq inside {SEQ_BYTE1, SEQ_BYTE2, SEQ_BYTE3, SEQ_WORD} |-> flash_io_oe == 4'd0
    );

    clock_idle_deselected: assert property (
        @(posedge clk) disable iff (reset)
        flash_csn && $past(flash_csn) |-> flash_clk && $stable(flash_clk)
    );

endmodule

// File: source/flash_pkg.sv
// Shared types for the SPI flash execute-in-place port.
// Compile before every module that imports it.

package flash_pkg;

    // Reader sequence. Each value names the slot that is set up next.
    typedef enum logic [3:0] {
        SEQ_CMD,
        SEQ_ADDR_HI,
        SEQ_ADDR_MID,
        SEQ_ADDR_LO,
        SEQ_MODE,
        SEQ_FIRST,
        SEQ_BYTE1,
        SEQ_BYTE2,
        SEQ_BYTE3,
        SEQ_WORD
    } flash_seq_e;

    typedef enum logic [7:0] {
        CMD_READ         = 8'h03,  // Single-line read.
        CMD_DUAL_IO_READ = 8'hBB   // Address and data on io1:0.
    } flash_cmd_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// File: source/flash_params.svh
// Default build settings for the SPI flash execute-in-place port.
// Include wherever the I/O mode or the bus widths are needed.

`ifndef FLASH_PARAMS_SVH
`define FLASH_PARAMS_SVH

// 1 selects the dual-I/O read (BB), 0 the single-line read (03).
`define FLASH_DUAL_IO 1

// Byte address width of the flash space, 16 MB.
`define FLASH_ADDR_W 24

// Width of one word as seen on the AXI side.
`define FLASH_DATA_W 32

`endif
